/* project.f */
+incdir+hw
hw/pcie_tlp_pkg.sv
hw/dll_tx_pkg.sv
hw/tlp_skid_buffer.sv
hw/fc_credit_gate.sv
hw/dll_framer.sv
hw/dll_tx_top.sv
testbench/tb_dll_tx.sv

/* Makefile */
# Verilator build and run of the PCIe data link transmitter testbench

SOURCES := project.f $(wildcard hw/*.sv hw/*.svh testbench/*.sv)

run: obj_dir/Vtb_dll_tx
	obj_dir/Vtb_dll_tx > sim.log; cat sim.log
	grep -q "^RESULT: PASS$$" sim.log

obj_dir/Vtb_dll_tx: $(SOURCES)
	verilator --binary --timing -j 0 --top-module tb_dll_tx -f project.f -Mdir obj_dir

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* testbench/tb_dll_tx.sv */
// ==========================================================================
// testbench for the PCIe data link transmit path
// builds expected frames from the credit and LCRC rules and compares
// ==========================================================================
`include "dll_tx_defs.svh"

module tb_dll_tx;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int DRAIN_TIMEOUT = 6000;
  localparam int STALL_TIMEOUT = 3000;

  logic                   clk_i;
  logic                   rst_i;
  dll_tx_pkg::tlp_beat_t  s_beat_i;
  logic                   s_valid_i;
  logic                   s_ready_o;
  dll_tx_pkg::tlp_beat_t  m_beat_o;
  logic                   m_valid_o;
  logic                   m_ready_i;
  logic                   update_fc_i;
  dll_tx_pkg::fc_limits_t fc_limits_i;
  dll_tx_pkg::seq_num_t   seq_num_o;
  logic                   dllp_valid_o;

  dll_tx_pkg::tlp_beat_t  drive_q[$];
  dll_tx_pkg::tlp_beat_t  expect_q[$];
  dll_tx_pkg::fc_limits_t used;
  dll_tx_pkg::seq_num_t   next_seq;
  logic [15:0]            lfsr_q;
  logic                   rand_ready;
  int                     errors;
  int                     done_cnt;

  dll_tx_top UUT (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .s_beat_i    (s_beat_i),
    .s_valid_i   (s_valid_i),
    .s_ready_o   (s_ready_o),
    .m_beat_o    (m_beat_o),
    .m_valid_o   (m_valid_o),
    .m_ready_i   (m_ready_i),
    .update_fc_i (update_fc_i),
    .fc_limits_i (fc_limits_i),
    .seq_num_o   (seq_num_o),
    .dllp_valid_o(dllp_valid_o)
  );

  // galois LFSR, one step per bit
  function automatic logic lfsr_bit();
    lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
    return lfsr_q[0];
  endfunction

  function automatic logic [31:0] rand_word(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_bit()};
    end
    return r;
  endfunction

  // CRC-32 over all words msb first, result inverted
  function automatic pcie_tlp_pkg::dword_t lcrc_ref(input pcie_tlp_pkg::dword_t words[$]);
    logic [31:0] rem;
    logic        top;
    rem = `DLL_LCRC_INIT;
    foreach (words[w]) begin
      for (int b = 31; b >= 0; b--) begin
        top = rem[31];
        rem = rem << 1;
        if (top ^ words[w][b]) begin
          rem = rem ^ `DLL_LCRC_POLY;
        end
      end
    end
    return ~rem;
  endfunction

  function automatic bit carries_data(input logic [7:0] code);
    return code inside {pcie_tlp_pkg::MWr, pcie_tlp_pkg::MsgD, pcie_tlp_pkg::CplD,
                        pcie_tlp_pkg::CplDLk, pcie_tlp_pkg::IOWr, pcie_tlp_pkg::CfgWr0,
                        pcie_tlp_pkg::CfgWr1};
  endfunction

  function automatic pcie_tlp_pkg::fc_class_e tlp_class(input logic [7:0] code);
    case (code)
      pcie_tlp_pkg::MWr, pcie_tlp_pkg::Msg, pcie_tlp_pkg::MsgD:
        return pcie_tlp_pkg::FC_POSTED;
      pcie_tlp_pkg::Cpl, pcie_tlp_pkg::CplD, pcie_tlp_pkg::CplLk, pcie_tlp_pkg::CplDLk:
        return pcie_tlp_pkg::FC_COMPLETION;
      default:
        return pcie_tlp_pkg::FC_NON_POSTED;
    endcase
  endfunction

  function automatic int payload_dw(input logic [7:0] code, input logic [9:0] len);
    if (!carries_data(code)) begin
      return 0;
    end
    return (len == 10'd0) ? 1024 : int'(len);
  endfunction

  // free credits well inside the modulo window
  function automatic dll_tx_pkg::fc_limits_t ample_limits();
    dll_tx_pkg::fc_limits_t lim;
    lim.ph   = used.ph + 8'd127;
    lim.nph  = used.nph + 8'd127;
    lim.cplh = used.cplh + 8'd127;
    lim.pd   = used.pd + 12'd2047;
    lim.npd  = used.npd + 12'd2047;
    lim.cpld = used.cpld + 12'd2047;
    return lim;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s is %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic finish_run(input string why);
    if (why != "") begin
      $display("%s", why);
    end
    $display("errors: %0d, TLPs framed: %0d", errors, done_cnt);
    if (why == "" && errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  // queue one 3DW TLP for the driver and its frame for the compare
  task automatic queue_tlp(input logic [7:0] code, input logic [9:0] len);
    pcie_tlp_pkg::dword_t  words[$];
    dll_tx_pkg::tlp_beat_t beat;
    logic [11:0]           need;
    words.push_back(pcie_tlp_pkg::dword_t'(next_seq));
    words.push_back({code, 14'd0, len});
    words.push_back(rand_word(32));
    words.push_back(rand_word(32));
    for (int i = 0; i < payload_dw(code, len); i++) begin
      words.push_back(rand_word(32));
    end
    for (int i = 1; i < words.size(); i++) begin
      beat.data = words[i];
      beat.last = (i == words.size() - 1);
      drive_q.push_back(beat);
    end
    foreach (words[i]) begin
      beat.data = words[i];
      beat.last = 1'b0;
      expect_q.push_back(beat);
    end
    beat.data = lcrc_ref(words);
    beat.last = 1'b1;
    expect_q.push_back(beat);
    need = 12'((payload_dw(code, len) + `DLL_DW_PER_CREDIT - 1) / `DLL_DW_PER_CREDIT);
    case (tlp_class(code))
      pcie_tlp_pkg::FC_POSTED: begin
        used.ph = used.ph + 8'd1;
        used.pd = used.pd + need;
      end
      pcie_tlp_pkg::FC_COMPLETION: begin
        used.cplh = used.cplh + 8'd1;
        used.cpld = used.cpld + need;
      end
      default: begin
        used.nph = used.nph + 8'd1;
        used.npd = used.npd + need;
      end
    endcase
    next_seq = next_seq + 12'd1;
  endtask

  task automatic load_limits(input dll_tx_pkg::fc_limits_t lim);
    @(posedge clk_i);
    fc_limits_i <= lim;
    update_fc_i <= 1'b1;
    @(posedge clk_i);
    update_fc_i <= 1'b0;
  endtask

  task automatic wait_drained(input string what);
    int cycles;
    cycles = 0;
    while (drive_q.size() != 0 || expect_q.size() != 0) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > DRAIN_TIMEOUT) begin
        finish_run($sformatf("timeout: %s did not come out of the DUT", what));
      end
    end
    // let seq_num_o settle after the last LCRC
    @(posedge clk_i);
  endtask

  task automatic wait_done(input int count, input string what);
    int cycles;
    cycles = 0;
    while (done_cnt < count) begin
      @(posedge clk_i);
      cycles++;
      if (cycles > DRAIN_TIMEOUT) begin
        finish_run($sformatf("timeout: waiting for %s", what));
      end
    end
  endtask

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #2 clk_i = ~clk_i;
    end
  end

  // input stream, one queued beat at a time
  initial begin : driver
    int stall;
    stall = 0;
    forever begin
      @(posedge clk_i);
      if (s_valid_i && s_ready_o) begin
        void'(drive_q.pop_front());
        stall = 0;
      end else if (s_valid_i) begin
        stall++;
        if (stall > STALL_TIMEOUT) begin
          finish_run("timeout: the DUT stopped taking input beats");
        end
      end
      if (!rst_i && drive_q.size() != 0) begin
        s_beat_i  <= drive_q[0];
        s_valid_i <= 1'b1;
      end else begin
        s_valid_i <= 1'b0;
      end
    end
  end

  initial begin : ready_gen
    forever begin
      @(posedge clk_i);
      m_ready_i <= rand_ready ? lfsr_bit() : 1'b1;
    end
  end

  // every beat that moves must be the next expected one
  initial begin : compare
    dll_tx_pkg::tlp_beat_t exp;
    dll_tx_pkg::seq_num_t  exp_seq;
    exp_seq = '0;
    forever begin
      @(posedge clk_i);
      if (!rst_i) begin
        check_value(32'(seq_num_o), 32'(exp_seq), "seq_num_o");
        if (m_valid_o && m_ready_i) begin
          if (expect_q.size() == 0) begin
            errors++;
            $display("[ERROR] %0t: beat %08h sent with nothing expected", $time,
                     m_beat_o.data);
          end else begin
            exp = expect_q.pop_front();
            check_value(m_beat_o.data, exp.data, "output word");
            check_value(32'(m_beat_o.last), 32'(exp.last), "last bit");
            check_value(32'(dllp_valid_o), 32'(exp.last), "dllp_valid_o on beat");
            // frame complete, the next one takes the following number
            if (exp.last) begin
              exp_seq = exp_seq + 1'b1;
            end
          end
        end else begin
          check_value(32'(dllp_valid_o), 32'd0, "dllp_valid_o with no beat moving");
        end
        if (dllp_valid_o) begin
          done_cnt++;
        end
      end
    end
  end

  initial begin : main
    dll_tx_pkg::fc_limits_t lim;
    logic [7:0]             codes [9];
    int                     start;
    int                     idx;
    rst_i       = 1'b1;
    s_beat_i    = '0;
    s_valid_i   = 1'b0;
    m_ready_i   = 1'b1;
    update_fc_i = 1'b0;
    fc_limits_i = '0;
    lfsr_q      = 16'd4016;
    rand_ready  = 1'b0;
    errors      = 0;
    done_cnt    = 0;
    used        = '0;
    next_seq    = '0;
    codes = '{pcie_tlp_pkg::MRd, pcie_tlp_pkg::Cpl, pcie_tlp_pkg::CplD, pcie_tlp_pkg::MWr,
              pcie_tlp_pkg::CfgWr0, pcie_tlp_pkg::Msg, pcie_tlp_pkg::MsgD, 8'h1F,
              pcie_tlp_pkg::IOWr};
    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;

    // limits are zero after reset, so the TLP must wait
    queue_tlp(pcie_tlp_pkg::MWr, 10'd4);
    repeat (200) begin
      @(posedge clk_i);
      check_value(32'(m_valid_o), 32'd0, "m_valid_o under zero limits");
    end
    load_limits(ample_limits());
    wait_drained("the TLP released by the first update");

    start = done_cnt;
    queue_tlp(pcie_tlp_pkg::MWr, 10'd6);
    wait_drained("a single MWr");
    check_value(32'(done_cnt - start), 32'd1, "dllp_valid_o pulses for one MWr");

    // mixed classes, an unknown code and a 1024 dword write
    foreach (codes[i]) begin
      queue_tlp(codes[i], 10'(rand_word(3) + 32'd1));
    end
    queue_tlp(pcie_tlp_pkg::MWr, 10'd0);
    wait_drained("the mixed class TLPs");
    check_value(32'(seq_num_o), 32'(next_seq), "next sequence number");

    // two posted headers free, third MWr held with a Cpl behind it
    lim = ample_limits();
    lim.ph = used.ph + 8'd2;
    load_limits(lim);
    start = done_cnt;
    repeat (3) queue_tlp(pcie_tlp_pkg::MWr, 10'd2);
    wait_done(start + 2, "the two MWr inside the posted limit");
    queue_tlp(pcie_tlp_pkg::Cpl, 10'd1);
    repeat (150) begin
      @(posedge clk_i);
      check_value(32'(m_valid_o), 32'd0, "m_valid_o while the third MWr is held");
    end
    lim.ph = used.ph;
    load_limits(lim);
    wait_drained("the held MWr and the Cpl after it");

    // random lengths under random backpressure
    load_limits(ample_limits());
    start = done_cnt;
    for (int t = 0; t < 20; t++) begin
      idx = int'(rand_word(4) % 32'd9);
      queue_tlp(codes[idx], 10'(rand_word(4) + 32'd1));
    end
    rand_ready <= 1'b1;
    wait_drained("the TLPs under random m_ready_i");
    rand_ready <= 1'b0;
    check_value(32'(done_cnt - start), 32'd20, "TLPs framed under random m_ready_i");

    finish_run("");
  end

endmodule

/* hw/dll_tx_top.sv */
// ==========================================================================
// PCIe data link layer transmit path
// skid buffer, credit gate and framer in a chain
// ==========================================================================
module dll_tx_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  dll_tx_pkg::tlp_beat_t  s_beat_i,
  input  logic                   s_valid_i,
  output logic                   s_ready_o,
  output dll_tx_pkg::tlp_beat_t  m_beat_o,
  output logic                   m_valid_o,
  input  logic                   m_ready_i,
  input  logic                   update_fc_i,
  input  dll_tx_pkg::fc_limits_t fc_limits_i,
  output dll_tx_pkg::seq_num_t   seq_num_o,
  output logic                   dllp_valid_o
);

  dll_tx_pkg::tlp_beat_t skid_beat;
  logic                  skid_valid;
  logic                  skid_ready;
  dll_tx_pkg::tlp_beat_t gate_beat;
  logic                  gate_valid;
  logic                  gate_ready;

  tlp_skid_buffer u_skid (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .in_beat_i  (s_beat_i),
    .in_valid_i (s_valid_i),
    .in_ready_o (s_ready_o),
    .out_beat_o (skid_beat),
    .out_valid_o(skid_valid),
    .out_ready_i(skid_ready)
  );

  fc_credit_gate u_gate (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .in_beat_i  (skid_beat),
    .in_valid_i (skid_valid),
    .in_ready_o (skid_ready),
    .out_beat_o (gate_beat),
    .out_valid_o(gate_valid),
    .out_ready_i(gate_ready),
    .update_fc_i(update_fc_i),
    .fc_limits_i(fc_limits_i)
  );

  dll_framer u_framer (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_beat_i   (gate_beat),
    .in_valid_i  (gate_valid),
    .in_ready_o  (gate_ready),
    .m_beat_o    (m_beat_o),
    .m_valid_o   (m_valid_o),
    .m_ready_i   (m_ready_i),
    .seq_num_o   (seq_num_o),
    .dllp_valid_o(dllp_valid_o)
  );

endmodule

/* hw/dll_framer.sv */
// ==========================================================================
// data link framer
// sends the sequence word, the TLP words and the inverted LCRC
// ==========================================================================
`include "dll_tx_defs.svh"

module dll_framer (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  dll_tx_pkg::tlp_beat_t in_beat_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  output dll_tx_pkg::tlp_beat_t m_beat_o,
  output logic                  m_valid_o,
  input  logic                  m_ready_i,
  output dll_tx_pkg::seq_num_t  seq_num_o,
  output logic                  dllp_valid_o
);

  dll_tx_pkg::framer_state_e state_q;
  dll_tx_pkg::tlp_beat_t     m_beat_q;
  logic                      m_valid_q;
  dll_tx_pkg::seq_num_t      seq_q;
  dll_tx_pkg::seq_num_t      seq_use;
  pcie_tlp_pkg::dword_t      seq_word;
  pcie_tlp_pkg::dword_t      crc_q;
  logic                      out_free;
  logic                      in_fire;

  // one dword through the CRC, msb first
  function automatic pcie_tlp_pkg::dword_t crc32_step(pcie_tlp_pkg::dword_t crc,
                                                      pcie_tlp_pkg::dword_t data);
    pcie_tlp_pkg::dword_t c;
    logic                 fb;
    c = crc;
    for (int i = `DLL_DW_WIDTH - 1; i >= 0; i--) begin
      fb = c[`DLL_DW_WIDTH-1] ^ data[i];
      c  = {c[`DLL_DW_WIDTH-2:0], 1'b0};
      if (fb) begin
        c = c ^ `DLL_LCRC_POLY;
      end
    end
    return c;
  endfunction

  assign out_free     = m_ready_i || !m_valid_q;
  assign in_fire      = in_valid_i && in_ready_o;
  assign dllp_valid_o = m_valid_q && m_ready_i && m_beat_q.last;

  // next TLP may start while the previous LCRC is leaving
  assign seq_use  = seq_q + dll_tx_pkg::seq_num_t'(dllp_valid_o);
  assign seq_word = {{(`DLL_DW_WIDTH - `DLL_SEQ_WIDTH){1'b0}}, seq_use};

  assign in_ready_o = (state_q == dll_tx_pkg::ST_DATA) && out_free;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= dll_tx_pkg::ST_SEQ;
      m_valid_q <= 1'b0;
      seq_q     <= '0;
    end else begin
      if (dllp_valid_o) begin
        seq_q <= seq_q + 1'b1;
      end
      if (out_free) begin
        m_valid_q <= 1'b0;
        case (state_q)
          dll_tx_pkg::ST_SEQ: begin
            // wait for a TLP before spending a sequence number
            if (in_valid_i) begin
              m_valid_q <= 1'b1;
              state_q   <= dll_tx_pkg::ST_DATA;
            end
          end
          dll_tx_pkg::ST_DATA: begin
            if (in_fire) begin
              m_valid_q <= 1'b1;
              if (in_beat_i.last) begin
                state_q <= dll_tx_pkg::ST_LCRC;
              end
            end
          end
          default: begin
            m_valid_q <= 1'b1;
            state_q   <= dll_tx_pkg::ST_SEQ;
          end
        endcase
      end
    end
  end

  // output word and running CRC
  always_ff @(posedge clk_i) begin
    if (out_free) begin
      case (state_q)
        dll_tx_pkg::ST_SEQ: begin
          if (in_valid_i) begin
            m_beat_q <= '{data: seq_word, last: 1'b0};
            crc_q    <= crc32_step(`DLL_LCRC_INIT, seq_word);
          end
        end
        dll_tx_pkg::ST_DATA: begin
          if (in_fire) begin
            m_beat_q <= '{data: in_beat_i.data, last: 1'b0};
            crc_q    <= crc32_step(crc_q, in_beat_i.data);
          end
        end
        default: begin
          m_beat_q <= '{data: ~crc_q, last: 1'b1};
        end
      endcase
    end
  end

  assign m_beat_o  = m_beat_q;
  assign m_valid_o = m_valid_q;
  assign seq_num_o = seq_q;

endmodule

/* hw/fc_credit_gate.sv */
// ==========================================================================
// flow control credit gate
// classifies each TLP from its header and holds it until the header
// and data credits of its class are available
// ==========================================================================
`include "dll_tx_defs.svh"

module fc_credit_gate (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  dll_tx_pkg::tlp_beat_t  in_beat_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  output dll_tx_pkg::tlp_beat_t  out_beat_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  input  logic                   update_fc_i,
  input  dll_tx_pkg::fc_limits_t fc_limits_i
);

  dll_tx_pkg::gate_state_e       state_q;
  dll_tx_pkg::tlp_beat_t         out_beat_q;
  logic                          out_valid_q;
  logic                          out_free;
  logic                          in_fire;
  dll_tx_pkg::fc_limits_t        limits_q;
  dll_tx_pkg::fc_limits_t        consumed_q;
  pcie_tlp_pkg::tlp_fmt_type_e   hdr_fmt_type;
  pcie_tlp_pkg::tlp_len_t        hdr_len;
  logic [`DLL_LEN_WIDTH:0]       len_dw;
  logic                          has_data;
  pcie_tlp_pkg::fc_class_e       dec_cls;
  pcie_tlp_pkg::data_credit_t    dec_req;
  pcie_tlp_pkg::fc_class_e       cls_q;
  pcie_tlp_pkg::data_credit_t    data_req_q;
  pcie_tlp_pkg::hdr_credit_t     hdr_free;
  pcie_tlp_pkg::data_credit_t    data_free;
  logic                          credit_ok;

  // header decode, only meaningful while the header beat is offered
  always_comb begin
    hdr_fmt_type = pcie_tlp_pkg::tlp_fmt_type_e'(
      in_beat_i.data[`DLL_FMT_TYPE_LSB +: `DLL_FMT_TYPE_WIDTH]);
    hdr_len = in_beat_i.data[`DLL_LEN_LSB +: `DLL_LEN_WIDTH];
    // zero length means 1024 dwords
    len_dw  = {hdr_len == '0, hdr_len};
    case (hdr_fmt_type)
      pcie_tlp_pkg::MWr, pcie_tlp_pkg::Msg, pcie_tlp_pkg::MsgD:
        dec_cls = pcie_tlp_pkg::FC_POSTED;
      pcie_tlp_pkg::Cpl, pcie_tlp_pkg::CplD, pcie_tlp_pkg::CplLk, pcie_tlp_pkg::CplDLk:
        dec_cls = pcie_tlp_pkg::FC_COMPLETION;
      default:
        dec_cls = pcie_tlp_pkg::FC_NON_POSTED;
    endcase
    has_data = hdr_fmt_type inside {pcie_tlp_pkg::MWr, pcie_tlp_pkg::MsgD,
                                    pcie_tlp_pkg::CplD, pcie_tlp_pkg::CplDLk,
                                    pcie_tlp_pkg::IOWr, pcie_tlp_pkg::CfgWr0,
                                    pcie_tlp_pkg::CfgWr1};
    dec_req = '0;
    if (has_data) begin
      dec_req = pcie_tlp_pkg::data_credit_t'(
        (len_dw + (`DLL_DW_PER_CREDIT - 1)) / `DLL_DW_PER_CREDIT);
    end
  end

  // free credits, modulo counter width
  always_comb begin
    hdr_free  = '0;
    data_free = '0;
    case (cls_q)
      pcie_tlp_pkg::FC_POSTED: begin
        hdr_free  = limits_q.ph - consumed_q.ph;
        data_free = limits_q.pd - consumed_q.pd;
      end
      pcie_tlp_pkg::FC_NON_POSTED: begin
        hdr_free  = limits_q.nph - consumed_q.nph;
        data_free = limits_q.npd - consumed_q.npd;
      end
      pcie_tlp_pkg::FC_COMPLETION: begin
        hdr_free  = limits_q.cplh - consumed_q.cplh;
        data_free = limits_q.cpld - consumed_q.cpld;
      end
      default: begin
      end
    endcase
    credit_ok = (hdr_free != '0) && (data_free >= data_req_q);
  end

  assign out_free = out_ready_i || !out_valid_q;
  assign in_fire  = in_valid_i && in_ready_o;

  always_comb begin
    case (state_q)
      dll_tx_pkg::ST_CHECK:  in_ready_o = credit_ok && out_free;
      dll_tx_pkg::ST_STREAM: in_ready_o = out_free;
      default:               in_ready_o = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= dll_tx_pkg::ST_IDLE;
      out_valid_q <= 1'b0;
      limits_q    <= '0;
      consumed_q  <= '0;
    end else begin
      if (update_fc_i) begin
        limits_q <= fc_limits_i;
      end
      if (in_fire) begin
        out_valid_q <= 1'b1;
      end else if (out_ready_i) begin
        out_valid_q <= 1'b0;
      end
      case (state_q)
        dll_tx_pkg::ST_IDLE: begin
          if (in_valid_i) begin
            state_q <= dll_tx_pkg::ST_CHECK;
          end
        end
        dll_tx_pkg::ST_CHECK: begin
          if (in_fire) begin
            // header leaves, charge its class
            case (cls_q)
              pcie_tlp_pkg::FC_POSTED: begin
                consumed_q.ph <= consumed_q.ph + 1'b1;
                consumed_q.pd <= consumed_q.pd + data_req_q;
              end
              pcie_tlp_pkg::FC_COMPLETION: begin
                consumed_q.cplh <= consumed_q.cplh + 1'b1;
                consumed_q.cpld <= consumed_q.cpld + data_req_q;
              end
              default: begin
                consumed_q.nph <= consumed_q.nph + 1'b1;
                consumed_q.npd <= consumed_q.npd + data_req_q;
              end
            endcase
            state_q <= in_beat_i.last ? dll_tx_pkg::ST_IDLE : dll_tx_pkg::ST_STREAM;
          end
        end
        default: begin
          if (in_fire && in_beat_i.last) begin
            state_q <= dll_tx_pkg::ST_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_fire) begin
      out_beat_q <= in_beat_i;
    end
    if (state_q == dll_tx_pkg::ST_IDLE) begin
      cls_q      <= dec_cls;
      data_req_q <= dec_req;
    end
  end

  assign out_beat_o  = out_beat_q;
  assign out_valid_o = out_valid_q;

endmodule

/* hw/tlp_skid_buffer.sv */
// ==========================================================================
// TLP skid buffer
// two register entries so that the input ready comes from a flop
// while one beat per cycle still gets through
// ==========================================================================
module tlp_skid_buffer (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  dll_tx_pkg::tlp_beat_t in_beat_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  output dll_tx_pkg::tlp_beat_t out_beat_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i
);

  dll_tx_pkg::tlp_beat_t out_beat_q;
  dll_tx_pkg::tlp_beat_t skid_beat_q;
  logic                  out_valid_q;
  logic                  skid_valid_q;
  logic                  out_free;
  logic                  in_fire;

  // output slot empty or draining this cycle
  assign out_free = out_ready_i || !out_valid_q;
  assign in_fire  = in_valid_i && in_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
    end else begin
      if (out_free) begin
        // skid entry goes first to keep order
        if (skid_valid_q) begin
          out_valid_q  <= 1'b1;
          skid_valid_q <= 1'b0;
        end else begin
          out_valid_q <= in_fire;
        end
      end else if (in_fire) begin
        skid_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (out_free) begin
      out_beat_q <= skid_valid_q ? skid_beat_q : in_beat_i;
    end else if (in_fire) begin
      skid_beat_q <= in_beat_i;
    end
  end

  assign in_ready_o  = !skid_valid_q;
  assign out_beat_o  = out_beat_q;
  assign out_valid_o = out_valid_q;

endmodule

/* hw/dll_tx_pkg.sv */
// ==========================================================================
// data link transmitter package
// stream beat, credit limit bundle and FSM state types
// ==========================================================================
`include "dll_tx_defs.svh"

package dll_tx_pkg;

  typedef logic [`DLL_SEQ_WIDTH-1:0] seq_num_t;

  typedef struct packed {
    pcie_tlp_pkg::dword_t data;
    logic                 last;
  } tlp_beat_t;

  // advertised limits, also reused for the consumed counters
  typedef struct packed {
    pcie_tlp_pkg::hdr_credit_t  ph;
    pcie_tlp_pkg::data_credit_t pd;
    pcie_tlp_pkg::hdr_credit_t  nph;
    pcie_tlp_pkg::data_credit_t npd;
    pcie_tlp_pkg::hdr_credit_t  cplh;
    pcie_tlp_pkg::data_credit_t cpld;
  } fc_limits_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CHECK,
    ST_STREAM
  } gate_state_e;

  typedef enum logic [1:0] {
    ST_SEQ,
    ST_DATA,
    ST_LCRC
  } framer_state_e;

endpackage

/* hw/pcie_tlp_pkg.sv */
// ==========================================================================
// PCIe TLP package
// header field types, fmt/type codes and flow control classes
// ==========================================================================
`include "dll_tx_defs.svh"

package pcie_tlp_pkg;

  typedef logic [`DLL_DW_WIDTH-1:0]        dword_t;
  // length in dwords, zero encodes 1024
  typedef logic [`DLL_LEN_WIDTH-1:0]       tlp_len_t;
  typedef logic [`DLL_HDR_CRED_WIDTH-1:0]  hdr_credit_t;
  typedef logic [`DLL_DATA_CRED_WIDTH-1:0] data_credit_t;

  // fmt[2:0] and type[4:0] as one byte
  typedef enum logic [`DLL_FMT_TYPE_WIDTH-1:0] {
    MRd    = 8'h00,
    MRdLk  = 8'h01,
    IORd   = 8'h02,
    CfgRd0 = 8'h04,
    CfgRd1 = 8'h05,
    Cpl    = 8'h0A,
    CplLk  = 8'h0B,
    Msg    = 8'h30,
    MWr    = 8'h40,
    IOWr   = 8'h42,
    CfgWr0 = 8'h44,
    CfgWr1 = 8'h45,
    CplD   = 8'h4A,
    CplDLk = 8'h4B,
    MsgD   = 8'h70
  } tlp_fmt_type_e;

  typedef enum logic [1:0] {
    FC_POSTED,
    FC_NON_POSTED,
    FC_COMPLETION
  } fc_class_e;

endpackage

/* hw/dll_tx_defs.svh */
// ==========================================================================
// data link transmitter widths, header field positions and LCRC constants
// ==========================================================================
`ifndef DLL_TX_DEFS_SVH
`define DLL_TX_DEFS_SVH

// stream and counter widths
`define DLL_DW_WIDTH        32
`define DLL_SEQ_WIDTH       12
`define DLL_HDR_CRED_WIDTH  8
`define DLL_DATA_CRED_WIDTH 12

// first header dword layout
`define DLL_FMT_TYPE_LSB    24
`define DLL_FMT_TYPE_WIDTH  8
`define DLL_LEN_LSB         0
`define DLL_LEN_WIDTH       10

// one data credit covers four dwords
`define DLL_DW_PER_CREDIT   4

// LCRC is the ethernet CRC-32
`define DLL_LCRC_POLY       32'h04C1_1DB7
`define DLL_LCRC_INIT       32'hFFFF_FFFF

`endif
